// File: hdl/rv_fetch_pkg.sv
package rv_fetch_pkg;

	localparam int XLEN = 32;

	// ----------------------------------------------------------
	// Major opcodes, bits 6:0 of the instruction word
	// ----------------------------------------------------------
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// funct7 values accepted on OP and OP_IMM
	localparam logic [6:0] F7_BASE   = 7'h00;
	localparam logic [6:0] F7_ALT    = 7'h20;
	localparam logic [6:0] F7_MULDIV = 7'h01;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
		ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_MUL, ALU_MULH,
		ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_REM
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT,
		BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
	} branch_e;

	typedef enum logic [1:0] {
		MEM_BYTE, MEM_HALF, MEM_WORD
	} mem_size_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		alu_op_e         alu_op;
		branch_e         branch;
		mem_size_e       mem_size;
		logic            alu_imm;
		logic            load;
		logic            store;
		logic            load_unsigned;
		logic            jal;
		logic            jalr;
		logic            lui;
		logic            auipc;
		logic            div_unsigned;
		logic            illegal;
	} decoded_t;

endpackage

// File: hdl/rv_pc.sv
`timescale 1ns/1ps

module rv_pc #(
	parameter logic [rv_fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          fetch_i,
	input  logic                          redirect_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] redirect_addr_i,
	output logic [rv_fetch_pkg::XLEN-1:0] fetch_addr_o
);

	localparam logic [rv_fetch_pkg::XLEN-1:0] PC_STEP = 4;

	logic [rv_fetch_pkg::XLEN-1:0] pc_q;
	logic                          take_redirect;

	// A redirect only counts when it comes with a fetch strobe
	assign take_redirect = fetch_i & redirect_i;

	// Address of the word read in this cycle
	assign fetch_addr_o = take_redirect ? redirect_addr_i : pc_q;

	// ----------------------------------------------------------
	// Sequential PC
	// ----------------------------------------------------------
	// Steps past whichever address was just fetched, so a
	// redirect target is followed by target + 4
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_q <= RESET_PC;
		end else if (fetch_i) begin
			pc_q <= fetch_addr_o + PC_STEP;
		end
	end

endmodule

// File: hdl/rv_imem.sv
`timescale 1ns/1ps

module rv_imem #(
	parameter int unsigned IMEM_WORDS = 256
) (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          fetch_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] fetch_addr_i,
	input  logic                          load_we_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] load_addr_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] load_data_i,
	output logic                          instr_valid_o,
	output logic [rv_fetch_pkg::XLEN-1:0] instr_o,
	output logic [rv_fetch_pkg::XLEN-1:0] instr_pc_o
);

	localparam int AW = $clog2(IMEM_WORDS);

	logic [rv_fetch_pkg::XLEN-1:0] mem [IMEM_WORDS];
	logic [AW-1:0]                 rd_idx;
	logic [AW-1:0]                 wr_idx;

	// Byte address to word index, upper bits drop off so the index wraps
	assign rd_idx = fetch_addr_i[AW+1:2];
	assign wr_idx = load_addr_i[AW+1:2];

	// ----------------------------------------------------------
	// Array with one write and one registered read port
	// ----------------------------------------------------------
	// Read sees the old word when a load hits the same index
	always_ff @(posedge clk_i) begin
		if (load_we_i) begin
			mem[wr_idx] <= load_data_i;
		end
		if (fetch_i) begin
			instr_o    <= mem[rd_idx];
			instr_pc_o <= fetch_addr_i;
		end
	end

	// One-cycle valid behind each strobe
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			instr_valid_o <= 1'b0;
		end else begin
			instr_valid_o <= fetch_i;
		end
	end

endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          instr_valid_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] instr_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] instr_pc_i,
	output logic                          dec_valid_o,
	output rv_fetch_pkg::decoded_t        dec_o
);

	logic [6:0]                    opcode;
	logic [2:0]                    funct3;
	logic [6:0]                    funct7;
	logic [rv_fetch_pkg::XLEN-1:0] imm_i;
	logic [rv_fetch_pkg::XLEN-1:0] imm_s;
	logic [rv_fetch_pkg::XLEN-1:0] imm_b;
	logic [rv_fetch_pkg::XLEN-1:0] imm_u;
	logic [rv_fetch_pkg::XLEN-1:0] imm_j;
	logic                          bad;
	rv_fetch_pkg::decoded_t        raw;
	rv_fetch_pkg::decoded_t        dec_d;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// ----------------------------------------------------------
	// Immediate formats, all sign-extended from bit 31
	// ----------------------------------------------------------
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	// Register indices only where the format carries them
	always_comb begin
		raw = '0;
		raw.pc = instr_pc_i;
		bad = 1'b0;
		case (opcode)
			rv_fetch_pkg::OPC_LUI: begin
				raw.lui = 1'b1;
				raw.rd  = instr_i[11:7];
				raw.imm = imm_u;
			end
			rv_fetch_pkg::OPC_AUIPC: begin
				raw.auipc = 1'b1;
				raw.rd    = instr_i[11:7];
				raw.imm   = imm_u;
			end
			rv_fetch_pkg::OPC_JAL: begin
				raw.jal    = 1'b1;
				raw.branch = rv_fetch_pkg::BR_JUMP;
				raw.rd     = instr_i[11:7];
				raw.imm    = imm_j;
			end
			rv_fetch_pkg::OPC_JALR: begin
				raw.jalr   = 1'b1;
				raw.branch = rv_fetch_pkg::BR_JUMP;
				raw.rd     = instr_i[11:7];
				raw.rs1    = instr_i[19:15];
				raw.imm    = imm_i;
			end
			rv_fetch_pkg::OPC_BRANCH: begin
				raw.rs1 = instr_i[19:15];
				raw.rs2 = instr_i[24:20];
				raw.imm = imm_b;
				case (funct3)
					3'b000:  raw.branch = rv_fetch_pkg::BR_BEQ;
					3'b001:  raw.branch = rv_fetch_pkg::BR_BNE;
					3'b100:  raw.branch = rv_fetch_pkg::BR_BLT;
					3'b101:  raw.branch = rv_fetch_pkg::BR_BGE;
					3'b110:  raw.branch = rv_fetch_pkg::BR_BLTU;
					3'b111:  raw.branch = rv_fetch_pkg::BR_BGEU;
					default: raw.branch = rv_fetch_pkg::BR_NONE;
				endcase
			end
			rv_fetch_pkg::OPC_LOAD, rv_fetch_pkg::OPC_STORE: begin
				raw.rs1 = instr_i[19:15];
				case (funct3[1:0])
					2'b00:   raw.mem_size = rv_fetch_pkg::MEM_BYTE;
					2'b01:   raw.mem_size = rv_fetch_pkg::MEM_HALF;
					default: raw.mem_size = rv_fetch_pkg::MEM_WORD;
				endcase
				if (opcode == rv_fetch_pkg::OPC_LOAD) begin
					raw.load          = 1'b1;
					raw.load_unsigned = funct3[2];
					raw.rd            = instr_i[11:7];
					raw.imm           = imm_i;
				end else begin
					raw.store = 1'b1;
					raw.rs2   = instr_i[24:20];
					raw.imm   = imm_s;
				end
			end
			rv_fetch_pkg::OPC_OP_IMM: begin
				raw.alu_imm = 1'b1;
				raw.rd      = instr_i[11:7];
				raw.rs1     = instr_i[19:15];
				raw.imm     = imm_i;
				case (funct3)
					3'b000: raw.alu_op = rv_fetch_pkg::ALU_ADD;
					3'b010: raw.alu_op = rv_fetch_pkg::ALU_SLT;
					3'b011: raw.alu_op = rv_fetch_pkg::ALU_SLTU;
					3'b100: raw.alu_op = rv_fetch_pkg::ALU_XOR;
					3'b110: raw.alu_op = rv_fetch_pkg::ALU_OR;
					3'b111: raw.alu_op = rv_fetch_pkg::ALU_AND;
					3'b001: begin
						raw.alu_op = rv_fetch_pkg::ALU_SLL;
						bad        = (funct7 != rv_fetch_pkg::F7_BASE);
					end
					default: begin
						// SRLI or SRAI, told apart by funct7
						raw.alu_op = (funct7 == rv_fetch_pkg::F7_ALT) ?
							rv_fetch_pkg::ALU_SRA : rv_fetch_pkg::ALU_SRL;
						bad = (funct7 != rv_fetch_pkg::F7_BASE) &&
							(funct7 != rv_fetch_pkg::F7_ALT);
					end
				endcase
			end
			rv_fetch_pkg::OPC_OP: begin
				raw.rd  = instr_i[11:7];
				raw.rs1 = instr_i[19:15];
				raw.rs2 = instr_i[24:20];
				if (funct7 == rv_fetch_pkg::F7_BASE) begin
					raw.alu_op = rv_fetch_pkg::alu_op_e'({1'b0, funct3} +
						((funct3 > 3'b000) ? 4'd1 : 4'd0) +
						((funct3 > 3'b101) ? 4'd1 : 4'd0));
				end else if (funct7 == rv_fetch_pkg::F7_ALT) begin
					raw.alu_op = (funct3 == 3'b101) ?
						rv_fetch_pkg::ALU_SRA : rv_fetch_pkg::ALU_SUB;
					bad = (funct3 != 3'b000) && (funct3 != 3'b101);
				end else if (funct7 == rv_fetch_pkg::F7_MULDIV) begin
					// Unsigned divide and remainder share the DIV and REM codes
					raw.div_unsigned = funct3[2] & funct3[0];
					case (funct3)
						3'b000:         raw.alu_op = rv_fetch_pkg::ALU_MUL;
						3'b001:         raw.alu_op = rv_fetch_pkg::ALU_MULH;
						3'b010:         raw.alu_op = rv_fetch_pkg::ALU_MULHSU;
						3'b011:         raw.alu_op = rv_fetch_pkg::ALU_MULHU;
						3'b100, 3'b101: raw.alu_op = rv_fetch_pkg::ALU_DIV;
						default:        raw.alu_op = rv_fetch_pkg::ALU_REM;
					endcase
				end else begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase
	end

	// Illegal words keep only their PC and the illegal flag
	always_comb begin
		dec_d = raw;
		if (bad) begin
			dec_d         = '0;
			dec_d.pc      = instr_pc_i;
			dec_d.illegal = 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Output register
	// ----------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			dec_o <= dec_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= instr_valid_i;
		end
	end

endmodule

// File: hdl/rv_fetch_decode_top.sv
`timescale 1ns/1ps

module rv_fetch_decode_top #(
	parameter logic [rv_fetch_pkg::XLEN-1:0] RESET_PC   = '0,
	parameter int unsigned                   IMEM_WORDS = 256
) (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          fetch_i,
	input  logic                          redirect_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] redirect_addr_i,
	input  logic                          load_we_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] load_addr_i,
	input  logic [rv_fetch_pkg::XLEN-1:0] load_data_i,
	output logic                          dec_valid_o,
	output logic [rv_fetch_pkg::XLEN-1:0] dec_pc_o,
	output logic [rv_fetch_pkg::XLEN-1:0] dec_imm_o,
	output logic [4:0]                    dec_rd_o,
	output logic [4:0]                    dec_rs1_o,
	output logic [4:0]                    dec_rs2_o,
	output rv_fetch_pkg::alu_op_e         dec_alu_op_o,
	output rv_fetch_pkg::branch_e         dec_branch_o,
	output rv_fetch_pkg::mem_size_e       dec_mem_size_o,
	output logic                          dec_alu_imm_o,
	output logic                          dec_load_o,
	output logic                          dec_store_o,
	output logic                          dec_load_unsigned_o,
	output logic                          dec_jal_o,
	output logic                          dec_jalr_o,
	output logic                          dec_lui_o,
	output logic                          dec_auipc_o,
	output logic                          dec_div_unsigned_o,
	output logic                          dec_illegal_o
);

	logic [rv_fetch_pkg::XLEN-1:0] fetch_addr;
	logic                          instr_valid;
	logic [rv_fetch_pkg::XLEN-1:0] instr;
	logic [rv_fetch_pkg::XLEN-1:0] instr_pc;
	rv_fetch_pkg::decoded_t        dec;

	rv_pc #(
		.RESET_PC(RESET_PC)
	) u_pc (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.fetch_i(fetch_i),
		.redirect_i(redirect_i),
		.redirect_addr_i(redirect_addr_i),
		.fetch_addr_o(fetch_addr)
	);

	rv_imem #(
		.IMEM_WORDS(IMEM_WORDS)
	) u_imem (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.fetch_i(fetch_i),
		.fetch_addr_i(fetch_addr),
		.load_we_i(load_we_i),
		.load_addr_i(load_addr_i),
		.load_data_i(load_data_i),
		.instr_valid_o(instr_valid),
		.instr_o(instr),
		.instr_pc_o(instr_pc)
	);

	rv_decoder u_decoder (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.instr_valid_i(instr_valid),
		.instr_i(instr),
		.instr_pc_i(instr_pc),
		.dec_valid_o(dec_valid_o),
		.dec_o(dec)
	);

	// ----------------------------------------------------------
	// Decoded record out as plain ports
	// ----------------------------------------------------------
	assign dec_pc_o            = dec.pc;
	assign dec_imm_o           = dec.imm;
	assign dec_rd_o            = dec.rd;
	assign dec_rs1_o           = dec.rs1;
	assign dec_rs2_o           = dec.rs2;
	assign dec_alu_op_o        = dec.alu_op;
	assign dec_branch_o        = dec.branch;
	assign dec_mem_size_o      = dec.mem_size;
	assign dec_alu_imm_o       = dec.alu_imm;
	assign dec_load_o          = dec.load;
	assign dec_store_o         = dec.store;
	assign dec_load_unsigned_o = dec.load_unsigned;
	assign dec_jal_o           = dec.jal;
	assign dec_jalr_o          = dec.jalr;
	assign dec_lui_o           = dec.lui;
	assign dec_auipc_o         = dec.auipc;
	assign dec_div_unsigned_o  = dec.div_unsigned;
	assign dec_illegal_o       = dec.illegal;

endmodule

// File: verification/rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// Reset drops on the edge that closes the last reset cycle
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// File: verification/tb_rv_fetch_decode.sv
`timescale 1ns/1ps

module tb_rv_fetch_decode;

	localparam int IMEM_WORDS     = 64;
	localparam int TIMEOUT_CYCLES = 4000;

	logic                          clk;
	logic                          reset;
	logic                          fetch;
	logic                          redirect;
	logic [31:0]                   redirect_addr;
	logic                          load_we;
	logic [31:0]                   load_addr;
	logic [31:0]                   load_data;
	logic                          dec_valid;
	logic [31:0]                   dec_pc;
	logic [31:0]                   dec_imm;
	logic [4:0]                    dec_rd;
	logic [4:0]                    dec_rs1;
	logic [4:0]                    dec_rs2;
	rv_fetch_pkg::alu_op_e         dec_alu_op;
	rv_fetch_pkg::branch_e         dec_branch;
	rv_fetch_pkg::mem_size_e       dec_mem_size;
	logic                          dec_alu_imm;
	logic                          dec_load;
	logic                          dec_store;
	logic                          dec_load_unsigned;
	logic                          dec_jal;
	logic                          dec_jalr;
	logic                          dec_lui;
	logic                          dec_auipc;
	logic                          dec_div_unsigned;
	logic                          dec_illegal;
	rv_fetch_pkg::decoded_t        got;

	// Shadow of the instruction memory and the expected PC
	logic [31:0]                   img [IMEM_WORDS];
	logic [31:0]                   model_pc = 32'h0;
	rv_fetch_pkg::decoded_t        exp_q [$];
	int                            issue_q [$];
	int                            seed = 87498;
	int                            cycles = 0;
	int                            errors = 0;
	int                            test_start_errors = 0;
	int                            tests_passed = 0;
	int                            tests_failed = 0;

	rv_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk (.clk_o(clk), .reset_o(reset));

	rv_fetch_decode_top #(
		.IMEM_WORDS(IMEM_WORDS)
	) dut0 (
		.clk_i(clk), .reset_i(reset), .fetch_i(fetch), .redirect_i(redirect),
		.redirect_addr_i(redirect_addr), .load_we_i(load_we), .load_addr_i(load_addr),
		.load_data_i(load_data), .dec_valid_o(dec_valid), .dec_pc_o(dec_pc),
		.dec_imm_o(dec_imm), .dec_rd_o(dec_rd), .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2),
		.dec_alu_op_o(dec_alu_op), .dec_branch_o(dec_branch), .dec_mem_size_o(dec_mem_size),
		.dec_alu_imm_o(dec_alu_imm), .dec_load_o(dec_load), .dec_store_o(dec_store),
		.dec_load_unsigned_o(dec_load_unsigned), .dec_jal_o(dec_jal), .dec_jalr_o(dec_jalr),
		.dec_lui_o(dec_lui), .dec_auipc_o(dec_auipc), .dec_div_unsigned_o(dec_div_unsigned),
		.dec_illegal_o(dec_illegal)
	);

	assign got = {dec_pc, dec_imm, dec_rd, dec_rs1, dec_rs2, dec_alu_op, dec_branch,
		dec_mem_size, dec_alu_imm, dec_load, dec_store, dec_load_unsigned, dec_jal,
		dec_jalr, dec_lui, dec_auipc, dec_div_unsigned, dec_illegal};

	// ----------------------------------------------------------
	// Reference decoder
	// ----------------------------------------------------------
	function automatic rv_fetch_pkg::alu_op_e base_op(logic [2:0] f3);
		case (f3)
			3'd0:    return rv_fetch_pkg::ALU_ADD;
			3'd1:    return rv_fetch_pkg::ALU_SLL;
			3'd2:    return rv_fetch_pkg::ALU_SLT;
			3'd3:    return rv_fetch_pkg::ALU_SLTU;
			3'd4:    return rv_fetch_pkg::ALU_XOR;
			3'd5:    return rv_fetch_pkg::ALU_SRL;
			3'd6:    return rv_fetch_pkg::ALU_OR;
			default: return rv_fetch_pkg::ALU_AND;
		endcase
	endfunction

	function automatic rv_fetch_pkg::alu_op_e muldiv_op(logic [2:0] f3);
		case (f3)
			3'd0:       return rv_fetch_pkg::ALU_MUL;
			3'd1:       return rv_fetch_pkg::ALU_MULH;
			3'd2:       return rv_fetch_pkg::ALU_MULHSU;
			3'd3:       return rv_fetch_pkg::ALU_MULHU;
			3'd4, 3'd5: return rv_fetch_pkg::ALU_DIV;
			default:    return rv_fetch_pkg::ALU_REM;
		endcase
	endfunction

	function automatic rv_fetch_pkg::decoded_t ref_decode(logic [31:0] w, logic [31:0] pc);
		rv_fetch_pkg::decoded_t d;
		logic [2:0]             f3;
		logic [6:0]             f7;
		logic                   ok;
		d = '0;
		f3 = w[14:12];
		f7 = w[31:25];
		ok = 1'b1;
		d.pc = pc;
		case (w[6:0])
			rv_fetch_pkg::OPC_LUI, rv_fetch_pkg::OPC_AUIPC: begin
				d.lui = (w[6:0] == rv_fetch_pkg::OPC_LUI);
				d.auipc = !d.lui;
				d.rd = w[11:7];
				d.imm = {w[31:12], 12'h000};
			end
			rv_fetch_pkg::OPC_JAL: begin
				d.jal = 1'b1;
				d.branch = rv_fetch_pkg::BR_JUMP;
				d.rd = w[11:7];
				d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			rv_fetch_pkg::OPC_JALR: begin
				d.jalr = 1'b1;
				d.branch = rv_fetch_pkg::BR_JUMP;
				d.rd = w[11:7];
				d.rs1 = w[19:15];
				d.imm = {{21{w[31]}}, w[30:20]};
			end
			rv_fetch_pkg::OPC_BRANCH: begin
				d.rs1 = w[19:15];
				d.rs2 = w[24:20];
				d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				case (f3)
					3'd0:    d.branch = rv_fetch_pkg::BR_BEQ;
					3'd1:    d.branch = rv_fetch_pkg::BR_BNE;
					3'd4:    d.branch = rv_fetch_pkg::BR_BLT;
					3'd5:    d.branch = rv_fetch_pkg::BR_BGE;
					3'd6:    d.branch = rv_fetch_pkg::BR_BLTU;
					3'd7:    d.branch = rv_fetch_pkg::BR_BGEU;
					default: d.branch = rv_fetch_pkg::BR_NONE;
				endcase
			end
			rv_fetch_pkg::OPC_LOAD, rv_fetch_pkg::OPC_STORE: begin
				d.rs1 = w[19:15];
				d.mem_size = (f3[1:0] == 2'd0) ? rv_fetch_pkg::MEM_BYTE :
					(f3[1:0] == 2'd1) ? rv_fetch_pkg::MEM_HALF : rv_fetch_pkg::MEM_WORD;
				if (w[6:0] == rv_fetch_pkg::OPC_LOAD) begin
					d.load = 1'b1;
					d.load_unsigned = f3[2];
					d.rd = w[11:7];
					d.imm = {{21{w[31]}}, w[30:20]};
				end else begin
					d.store = 1'b1;
					d.rs2 = w[24:20];
					d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
				end
			end
			rv_fetch_pkg::OPC_OP_IMM: begin
				d.alu_imm = 1'b1;
				d.rd = w[11:7];
				d.rs1 = w[19:15];
				d.imm = {{21{w[31]}}, w[30:20]};
				d.alu_op = base_op(f3);
				if (f3 == 3'd1) begin
					ok = (f7 == 7'h00);
				end else if (f3 == 3'd5) begin
					ok = (f7 == 7'h00) || (f7 == 7'h20);
					if (f7 == 7'h20) begin
						d.alu_op = rv_fetch_pkg::ALU_SRA;
					end
				end
			end
			rv_fetch_pkg::OPC_OP: begin
				d.rd = w[11:7];
				d.rs1 = w[19:15];
				d.rs2 = w[24:20];
				if (f7 == 7'h00) begin
					d.alu_op = base_op(f3);
				end else if (f7 == 7'h20) begin
					ok = (f3 == 3'd0) || (f3 == 3'd5);
					d.alu_op = (f3 == 3'd5) ? rv_fetch_pkg::ALU_SRA : rv_fetch_pkg::ALU_SUB;
				end else if (f7 == 7'h01) begin
					d.alu_op = muldiv_op(f3);
					d.div_unsigned = (f3 == 3'd5) || (f3 == 3'd7);
				end else begin
					ok = 1'b0;
				end
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			d = '0;
			d.pc = pc;
			d.illegal = 1'b1;
		end
		return d;
	endfunction

	// ----------------------------------------------------------
	// Compare tasks and test bookkeeping
	// ----------------------------------------------------------
	task automatic check_pc(logic [31:0] got_pc, logic [31:0] exp_pc);
		if (got_pc !== exp_pc) begin
			$display("Error: dec_pc_o got %h expected %h", got_pc, exp_pc);
			errors++;
		end
	endtask

	task automatic check_decoded(rv_fetch_pkg::decoded_t g, rv_fetch_pkg::decoded_t e);
		if (g !== e) begin
			$display("Error: decoded record dec_*_o at pc %h got %h expected %h", e.pc, g, e);
			errors++;
		end
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	task automatic finish_test(string name);
		if (errors == test_start_errors) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", name, errors - test_start_errors);
			tests_failed++;
		end
	endtask

	// ----------------------------------------------------------
	// Drivers
	// ----------------------------------------------------------
	task automatic load_word(logic [31:0] addr, logic [31:0] data);
		@(posedge clk);
		load_we <= 1'b1;
		load_addr <= addr;
		load_data <= data;
		img[(addr >> 2) % IMEM_WORDS] = data;
	endtask

	task automatic idle();
		@(posedge clk);
		fetch <= 1'b0;
		redirect <= 1'b0;
		load_we <= 1'b0;
	endtask

	task automatic fetch_word(logic redir, logic [31:0] target);
		logic [31:0] addr;
		@(posedge clk);
		addr = redir ? target : model_pc;
		fetch <= 1'b1;
		redirect <= redir;
		redirect_addr <= target;
		load_we <= 1'b0;
		model_pc = addr + 32'd4;
		exp_q.push_back(ref_decode(img[(addr >> 2) % IMEM_WORDS], addr));
		// This edge is counted at the following negedge
		issue_q.push_back(cycles + 1);
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// ADDI whose fields follow all six index bits
	function automatic logic [31:0] fill_word(int i);
		logic [5:0] k;
		k = i[5:0];
		return {k, ~k, ~k[4:0], 3'b000, k[4:0], rv_fetch_pkg::OPC_OP_IMM};
	endfunction

	task automatic random_word(output logic [31:0] w);
		logic [31:0] g;
		int          kind;
		w = $random(seed);
		g = $random(seed);
		kind = g[7:4] % 9;
		case (kind)
			0: w[6:0] = rv_fetch_pkg::OPC_OP;
			1: w[6:0] = rv_fetch_pkg::OPC_OP_IMM;
			2: w[6:0] = rv_fetch_pkg::OPC_LOAD;
			3: w[6:0] = rv_fetch_pkg::OPC_STORE;
			4: w[6:0] = rv_fetch_pkg::OPC_BRANCH;
			5: w[6:0] = rv_fetch_pkg::OPC_JALR;
			6: w[6:0] = rv_fetch_pkg::OPC_LUI;
			7: w[6:0] = rv_fetch_pkg::OPC_AUIPC;
			default: w[6:0] = rv_fetch_pkg::OPC_JAL;
		endcase
		// Bend funct3 and funct7 onto a legal encoding
		if (kind == 0) begin
			w[31:25] = (g[1:0] == 2'd0) ? 7'h00 : (g[1:0] == 2'd1) ? 7'h01 : 7'h20;
			if (g[1]) begin
				w[14:12] = g[2] ? 3'd5 : 3'd0;
			end
		end else if (kind == 1 && w[13:12] == 2'b01) begin
			w[31:25] = (w[14] && g[0]) ? 7'h20 : 7'h00;
		end else if (kind == 2 || kind == 3) begin
			w[13] = w[13] & ~w[12];
			w[14] = w[14] & ~w[13] & (kind == 2);
		end else if (kind == 4 && w[14:13] == 2'b01) begin
			w[14] = 1'b1;
		end else if (kind == 5) begin
			w[14:12] = 3'd0;
		end
	endtask

	// ----------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------
	task automatic test_reset();
		start_test();
		while (reset) begin
			@(negedge clk);
		end
		@(negedge clk);
		if (dec_valid !== 1'b0) begin
			$display("Error: dec_valid_o got %h expected 0 after reset", dec_valid);
			errors++;
		end
		fetch_word(1'b0, 32'h0);
		idle();
		drain();
		finish_test("test_reset");
	endtask

	task automatic test_sequential_fetch();
		start_test();
		repeat (8) begin
			fetch_word(1'b0, 32'h0);
			idle();
			idle();
		end
		repeat (8) fetch_word(1'b0, 32'h0);
		idle();
		drain();
		finish_test("test_sequential_fetch");
	endtask

	task automatic test_redirect();
		start_test();
		fetch_word(1'b1, 32'h40);
		fetch_word(1'b0, 32'h0);
		fetch_word(1'b0, 32'h0);
		// Past the 64-word depth, lands on word 2
		fetch_word(1'b1, 32'h108);
		fetch_word(1'b0, 32'h0);
		idle();
		drain();
		finish_test("test_redirect");
	endtask

	task automatic run_words(logic [31:0] base, logic [31:0] words [], string name);
		start_test();
		foreach (words[i]) begin
			load_word(base + 4 * i, words[i]);
		end
		idle();
		foreach (words[i]) begin
			fetch_word(i == 0, base);
		end
		idle();
		drain();
		finish_test(name);
	endtask

	task automatic test_formats();
		logic [31:0] words [];
		// add, sub, mul, divu, rem, addi, srai, slli, sltiu, lbu, lhu, lw,
		// sw, sb, beq, bgeu, blt, lui, auipc, jal, jalr
		words = '{32'h002081B3, 32'h407302B3, 32'h02C58533, 32'h02F756B3, 32'h023160B3,
			32'hFFF10093, 32'h4032D213, 32'h01F39313, 32'h8004B413, 32'hFFC5C503,
			32'h0066D603, 32'h00012083, 32'hFEE7AC23, 32'h001101A3, 32'hFE2088E3,
			32'h0041F463, 32'h0062C863, 32'hABCDE3B7, 32'hFFFFF417, 32'hFFDFF0EF,
			32'hFF408067};
		run_words(32'h80, words, "test_formats");
	endtask

	task automatic test_illegal();
		logic [31:0] words [];
		// Bad opcodes, bad funct7 on OP and OP_IMM, then a plain addi
		words = '{32'h0000007F, 32'h00000000, 32'h0000000B, 32'h202081B3,
			32'h402091B3, 32'h41F39313, 32'h0232D213, 32'hFFF10093};
		run_words(32'hD0, words, "test_illegal");
	endtask

	task automatic test_random_stream();
		logic [31:0] w;
		logic [31:0] r;
		start_test();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			random_word(w);
			load_word(4 * i, w);
		end
		idle();
		fetch_word(1'b1, 32'h0);
		repeat (IMEM_WORDS - 1) begin
			r = $random(seed);
			fetch_word(r[2:0] == 3'd0, {22'd0, r[9:3], 3'b000});
		end
		idle();
		drain();
		finish_test("test_random_stream");
	endtask

	// ----------------------------------------------------------
	// Scoreboard, latency check and timeout
	// ----------------------------------------------------------
	always @(negedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end else if (dec_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("dec_valid_o went high with no fetch outstanding");
				errors++;
			end else begin
				if (cycles - issue_q[0] != 2) begin
					$display("Decoded record came %0d cycles after its fetch instead of 2",
						cycles - issue_q[0]);
					errors++;
				end
				check_pc(dec_pc, exp_q[0].pc);
				check_decoded(got, exp_q.pop_front());
				void'(issue_q.pop_front());
			end
		end else if (dec_valid !== 1'b0) begin
			$display("dec_valid_o is unknown");
			errors++;
		end
	end

	initial begin
		fetch <= 1'b0;
		redirect <= 1'b0;
		redirect_addr <= 32'h0;
		load_we <= 1'b0;
		load_addr <= 32'h0;
		load_data <= 32'h0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			load_word(4 * i, fill_word(i));
		end
		idle();
		test_reset();
		test_sequential_fetch();
		test_redirect();
		test_formats();
		test_illegal();
		test_random_stream();
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
hdl/rv_fetch_pkg.sv
hdl/rv_pc.sv
hdl/rv_imem.sv
hdl/rv_decoder.sv
hdl/rv_fetch_decode_top.sv
verification/rv_clock_gen.sv
verification/tb_rv_fetch_decode.sv

// File: Bender.yml
package:
  name: rv_fetch_decode

sources:
  - hdl/rv_fetch_pkg.sv
  - hdl/rv_pc.sv
  - hdl/rv_imem.sv
  - hdl/rv_decoder.sv
  - hdl/rv_fetch_decode_top.sv
  - target: simulation
    files:
      - verification/rv_clock_gen.sv
      - verification/tb_rv_fetch_decode.sv
